/* dv/golden_mem.txt */
// op (0 read, 1 write, 2 flush, 3 pass, 4 poke, f end) _ width (0 byte, 1 half, 2 word)
// _ signed _ address _ data _ expected rd
1_2_0_00000100_8281F07F_8281F07F
0_2_0_00000100_00000000_8281F07F
3_2_0_00000000_DEADBEEF_DEADBEEF
0_0_1_00000100_00000000_0000007F
0_0_0_00000101_00000000_000000F0
0_0_1_00000102_00000000_FFFFFF81
0_0_0_00000103_00000000_00000082
0_1_1_00000100_00000000_FFFFF07F
0_1_0_00000102_00000000_00008281
1_0_0_00000100_000000A1_000000A1
0_2_0_00000100_00000000_8281F0A1
1_0_0_00000101_123456B2_123456B2
0_2_0_00000100_00000000_8281B2A1
1_0_0_00000102_000000C3_000000C3
0_2_0_00000100_00000000_82C3B2A1
1_0_0_00000103_000000D4_000000D4
0_2_0_00000100_00000000_D4C3B2A1
1_1_0_00000100_5555E5F6_5555E5F6
0_2_0_00000100_00000000_D4C3E5F6
1_1_0_00000102_00001728_00001728
0_2_0_00000100_00000000_1728E5F6
4_2_0_20000040_11112222_00000000
0_2_0_20000040_00000000_11112222
4_2_0_20000040_33334444_00000000
0_2_0_20000040_00000000_11112222
2_2_0_00000000_0F0F0F0F_0F0F0F0F
0_2_0_20000040_00000000_33334444
1_2_0_20000040_55667788_55667788
0_2_0_20000040_00000000_55667788
0_2_0_00000040_00000000_55667788
f_0_0_00000000_00000000_00000000

/* sim.f */
verilog/stage_pkg.sv
verilog/bus_pkg.sv
verilog/memory_stage.sv
verilog/data_cache.sv
verilog/apb_bridge.sv
verilog/memory_subsystem.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f sim.f --Mdir obj_dir
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* dv/tb_top.sv */
`default_nettype none

module tb_top;

	timeunit 1ns;
	timeprecision 100ps;

	import stage_pkg::*;
	import bus_pkg::*;

	localparam int MAX_STEPS = 64;
	localparam int CYCLES_PER_STEP = 64;
	localparam logic [3:0] OP_READ = 4'h0;
	localparam logic [3:0] OP_WRITE = 4'h1;
	localparam logic [3:0] OP_FLUSH = 4'h2;
	localparam logic [3:0] OP_POKE = 4'h4;
	localparam logic [3:0] OP_END = 4'hf;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] width;
		logic [3:0] is_signed;
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] expected;
	} golden_step_t;

	typedef struct packed {
		logic valid;
		logic [31:0] address;
		logic [31:0] data;
	} poke_t;

	logic clock;
	logic reset;
	execute_data_t exec_data;
	logic busy;
	memory_data_t mem_data;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	memory_data_t expected;
	logic check;
	logic busy_check;
	logic busy_expected;
	int checks;
	int errors;
	poke_t poke;
	logic [107:0] golden [MAX_STEPS];
	logic [31:0] apb_mem [256];
	logic [31:0] rng_state;
	int wait_left;
	int step_count;
	int record_count;
	int cycle_limit;
	int cycles;
	int current_step;
	tag_t next_tag;

	tb_clock clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	memory_subsystem uut (
		.i_clock(clock),
		.i_reset(reset),
		.i_data(exec_data),
		.o_busy(busy),
		.o_data(mem_data),
		.o_apb(apb_req),
		.i_apb(apb_rsp)
	);

	tb_checker data_check (
		.i_clock(clock),
		.i_check(check),
		.i_actual(mem_data),
		.i_expected(expected),
		.i_busy(busy),
		.i_busy_check(busy_check),
		.i_busy_expected(busy_expected),
		.o_checks(checks),
		.o_errors(errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Word-addressed APB memory with 0 to 3 wait states per access
	initial begin
		apb_rsp = '0;
		wait_left = 0;
		rng_state = 32'd69;
		for (int i = 0; i < 256; i++) begin
			apb_mem[i] = {8'ha0, i[7:0], ~i[7:0], 8'h5c};
		end
		forever begin
			@(negedge clock);
			apb_rsp.pready = 1'b0;
			if (poke.valid) begin
				apb_mem[poke.address[9:2]] = poke.data;
			end
			if (apb_req.psel && !apb_req.penable) begin
				rng_state = xorshift(rng_state);
				wait_left = rng_state % 4;
			end else if (apb_req.psel && apb_req.penable) begin
				if (wait_left == 0) begin
					apb_rsp.pready = 1'b1;
					apb_rsp.prdata = apb_mem[apb_req.paddr[9:2]];
					if (apb_req.pwrite) begin
						apb_mem[apb_req.paddr[9:2]] = apb_req.pwdata;
					end
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	task automatic wait_retire();
		while (busy || mem_data.tag != exec_data.tag) begin
			@(negedge clock);
		end
	endtask

	task automatic run_step(input int index);
		golden_step_t step;
		execute_data_t record;
		step = golden[index];
		current_step = index;
		if (step.op == OP_POKE) begin
			poke <= '{valid: 1'b1, address: step.address, data: step.data};
			@(negedge clock);
			poke.valid <= 1'b0;
			@(negedge clock);
		end else begin
			next_tag = next_tag + 1'b1;
			record = '{tag: next_tag, mem_read: step.op == OP_READ,
				mem_write: step.op == OP_WRITE, mem_flush: step.op == OP_FLUSH,
				mem_width: mem_width_t'(step.width[1:0]), mem_signed: step.is_signed[0],
				mem_address: step.address, rd: step.data, inst_rd: 5'(index)};
			exec_data <= record;
			busy_expected <= step.op == OP_READ || step.op == OP_WRITE || step.op == OP_FLUSH;
			busy_check <= 1'b1;
			@(negedge clock);
			busy_check <= 1'b0;
			wait_retire();
			expected <= '{tag: next_tag, rd: step.expected, inst_rd: 5'(index)};
			check <= 1'b1;
			@(negedge clock);
			check <= 1'b0;
		end
	endtask

	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: step %0d did not retire within the limit of %0d cycles", current_step,
			cycle_limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		exec_data = '0;
		poke = '0;
		expected = '0;
		check = 1'b0;
		busy_check = 1'b0;
		busy_expected = 1'b0;
		next_tag = '0;
		current_step = 0;
		$readmemh("dv/golden_mem.txt", golden);
		step_count = 0;
		record_count = 0;
		while (step_count < MAX_STEPS && golden[step_count][107:104] != OP_END) begin
			if (golden[step_count][107:104] != OP_POKE) begin
				record_count++;
			end
			step_count++;
		end
		cycle_limit = step_count * CYCLES_PER_STEP;
		wait (!reset);
		@(negedge clock);
		for (int i = 0; i < step_count; i++) begin
			run_step(i);
		end
		repeat (2) @(negedge clock);
		if (record_count == 0 || checks != record_count) begin
			$display("Only %0d of %0d records were checked", checks, record_count);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && record_count > 0 && checks == record_count) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
`default_nettype none

module tb_checker (
	input wire logic i_clock,
	input wire logic i_check,
	input wire stage_pkg::memory_data_t i_actual,
	input wire stage_pkg::memory_data_t i_expected,
	input wire logic i_busy,
	input wire logic i_busy_check,
	input wire logic i_busy_expected,
	output int o_checks,
	output int o_errors
);

	timeunit 1ns;
	timeprecision 100ps;

	import stage_pkg::*;

	task automatic compare_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			o_errors++;
			$display("[ERROR] %s expected 0x%08h, got 0x%08h at %0t ns", name, expected, actual,
				$time);
		end
	endtask

	// The record is compared on the rising edge after the DUT has retired it
	initial begin
		o_checks = 0;
		o_errors = 0;
		forever begin
			@(posedge i_clock);
			// Busy is sampled on the first rising edge after a new record appears
			if (i_busy_check) begin
				compare_field("o_busy", 32'(i_busy_expected), 32'(i_busy));
			end
			if (i_check) begin
				o_checks++;
				compare_field("o_data.tag", 32'(i_expected.tag), 32'(i_actual.tag));
				compare_field("o_data.rd", i_expected.rd, i_actual.rd);
				compare_field("o_data.inst_rd", 32'(i_expected.inst_rd), 32'(i_actual.inst_rd));
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic o_clock,
	output logic o_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clock = 1'b0;
		forever #20 o_clock = ~o_clock;
	end

	// Reset drops on a falling edge, away from the edge the DUT samples on
	initial begin
		o_reset = 1'b1;
		repeat (2) @(posedge o_clock);
		@(negedge o_clock);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/memory_subsystem.sv */
`default_nettype none

module memory_subsystem (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire stage_pkg::execute_data_t i_data,
	output logic o_busy,
	output stage_pkg::memory_data_t o_data,
	output bus_pkg::apb_req_t o_apb,
	input wire bus_pkg::apb_rsp_t i_apb
);

	import bus_pkg::*;

	mem_req_t stage_req;
	mem_rsp_t stage_rsp;
	mem_req_t bus_req;
	mem_rsp_t bus_rsp;

	memory_stage stage (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(i_data),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_req(stage_req),
		.i_rsp(stage_rsp)
	);

	data_cache dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(stage_req),
		.o_rsp(stage_rsp),
		.o_req(bus_req),
		.i_rsp(bus_rsp)
	);

	apb_bridge bridge (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(bus_req),
		.o_rsp(bus_rsp),
		.o_apb(o_apb),
		.i_apb(i_apb)
	);

endmodule

`default_nettype wire

/* verilog/apb_bridge.sv */
`default_nettype none

module apb_bridge (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire bus_pkg::mem_req_t i_req,
	output bus_pkg::mem_rsp_t o_rsp,
	output bus_pkg::apb_req_t o_apb,
	input wire bus_pkg::apb_rsp_t i_apb
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_t;

	state_t state;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_apb <= '0;
			o_rsp <= '0;
		end else begin
			o_rsp.ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_req.valid && !o_rsp.ready) begin
						o_apb.psel <= 1'b1;
						o_apb.penable <= 1'b0;
						o_apb.pwrite <= i_req.rw;
						o_apb.paddr <= i_req.address.word;
						o_apb.pwdata <= i_req.wdata;
						state <= ST_SETUP;
					end
				end

				ST_SETUP: begin
					o_apb.penable <= 1'b1;
					state <= ST_ACCESS;
				end

				ST_ACCESS: begin
					// Wait states stretch the access phase
					if (i_apb.pready) begin
						o_apb.psel <= 1'b0;
						o_apb.penable <= 1'b0;
						o_rsp.ready <= 1'b1;
						o_rsp.rdata <= i_apb.prdata;
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/data_cache.sv */
`default_nettype none

module data_cache (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire bus_pkg::mem_req_t i_req,
	output bus_pkg::mem_rsp_t o_rsp,
	output bus_pkg::mem_req_t o_req,
	input wire bus_pkg::mem_rsp_t i_rsp
);

	import bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_FLUSH
	} state_t;

	state_t state;
	logic [DCACHE_LINES-1:0] line_valid;
	logic [DCACHE_TAG_BITS-1:0] line_tag [DCACHE_LINES];
	logic [31:0] line_data [DCACHE_LINES];
	logic [DCACHE_INDEX_BITS-1:0] index;
	logic [DCACHE_INDEX_BITS-1:0] flush_index;
	logic local_ready;
	logic [31:0] local_rdata;
	logic hit;
	logic accept;
	logic read_hit;
	logic line_write;

	assign index = i_req.address.fields.index;
	assign hit = line_valid[index] && line_tag[index] == i_req.address.fields.tag;

	// The ready cycle still sees valid high and must not start a new access
	assign accept = state == ST_IDLE && i_req.valid && !o_rsp.ready;
	assign read_hit = accept && !i_req.flush && i_req.cacheable && !i_req.rw && hit;
	assign line_write = state == ST_BUS && i_rsp.ready && i_req.cacheable && (!i_req.rw || hit);

	// Bus responses pass straight back in the cycle they arrive
	assign o_rsp.ready = local_ready || (state == ST_BUS && i_rsp.ready);
	assign o_rsp.rdata = (state == ST_BUS) ? i_rsp.rdata : local_rdata;

	always_ff @(posedge i_clock) begin
		if (line_write) begin
			line_tag[index] <= i_req.address.fields.tag;
			line_data[index] <= i_req.rw ? i_req.wdata : i_rsp.rdata;
		end
		if (read_hit) begin
			local_rdata <= line_data[index];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			line_valid <= '0;
			flush_index <= '0;
			local_ready <= 1'b0;
			o_req <= '0;
		end else begin
			local_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (i_req.flush) begin
							line_valid[flush_index] <= 1'b0;
							flush_index <= flush_index + 1'b1;
							state <= ST_FLUSH;
						end else if (read_hit) begin
							local_ready <= 1'b1;
						end else begin
							o_req <= i_req;
							state <= ST_BUS;
						end
					end
				end

				ST_BUS: begin
					if (i_rsp.ready) begin
						o_req.valid <= 1'b0;
						if (line_write) begin
							line_valid[index] <= 1'b1;
						end
						state <= ST_IDLE;
					end
				end

				ST_FLUSH: begin
					line_valid[flush_index] <= 1'b0;
					flush_index <= flush_index + 1'b1;
					if (flush_index == '1) begin
						local_ready <= 1'b1;
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`default_nettype none

module memory_stage (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire stage_pkg::execute_data_t i_data,
	output logic o_busy,
	output stage_pkg::memory_data_t o_data,
	output bus_pkg::mem_req_t o_req,
	input wire bus_pkg::mem_rsp_t i_rsp
);

	import stage_pkg::*;
	import bus_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_WORD,
		ST_RMW_READ,
		ST_RMW_WRITE,
		ST_FLUSH
	} state_t;

	state_t state;
	mem_addr_u addr;
	logic new_record;

	assign addr.word = i_data.mem_address;
	assign new_record = i_data.tag != o_data.tag;
	assign o_busy = new_record && (i_data.mem_read || i_data.mem_write || i_data.mem_flush);

	function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] offset,
			input mem_width_t width, input logic is_signed);
		logic [31:0] shifted;
		logic [31:0] result;
		shifted = word >> {offset, 3'b000};
		case (width)
			MEM_WIDTH_BYTE: result = {{24{is_signed & shifted[7]}}, shifted[7:0]};
			MEM_WIDTH_HALF: result = {{16{is_signed & shifted[15]}}, shifted[15:0]};
			default: result = word;
		endcase
		return result;
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] old_word,
			input logic [31:0] store_data, input logic [1:0] offset, input mem_width_t width);
		logic [31:0] result;
		result = old_word;
		if (width == MEM_WIDTH_BYTE) begin
			result[{offset, 3'b000} +: 8] = store_data[7:0];
		end else if (offset[0]) begin
			// Misaligned half stores clear the whole word
			result = '0;
		end else begin
			result[{offset[1], 4'b0000} +: 16] = store_data[15:0];
		end
		return result;
	endfunction

	function automatic memory_data_t retired(input logic [31:0] value);
		return '{tag: i_data.tag, rd: value, inst_rd: i_data.inst_rd};
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_req <= '0;
			o_data <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (new_record) begin
						o_req.address.word <= {addr.word[31:2], 2'b00};
						o_req.cacheable <= addr.fields.region == CACHEABLE_REGION;
						o_req.rw <= 1'b0;
						o_req.flush <= 1'b0;
						if (i_data.mem_read) begin
							o_req.valid <= 1'b1;
							state <= ST_READ;
						end else if (i_data.mem_write) begin
							o_req.valid <= 1'b1;
							if (i_data.mem_width == MEM_WIDTH_WORD) begin
								o_req.rw <= 1'b1;
								o_req.wdata <= i_data.rd;
								state <= ST_WRITE_WORD;
							end else begin
								// Narrow stores read the word first
								state <= ST_RMW_READ;
							end
						end else if (i_data.mem_flush) begin
							o_req.valid <= 1'b1;
							o_req.flush <= 1'b1;
							state <= ST_FLUSH;
						end else begin
							o_data <= retired(i_data.rd);
						end
					end
				end

				ST_READ: begin
					if (i_rsp.ready) begin
						o_req.valid <= 1'b0;
						o_data <= retired(load_value(i_rsp.rdata, addr.fields.offset,
							i_data.mem_width, i_data.mem_signed));
						state <= ST_IDLE;
					end
				end

				ST_WRITE_WORD: begin
					if (i_rsp.ready) begin
						o_req.valid <= 1'b0;
						o_req.rw <= 1'b0;
						o_data <= retired(i_data.rd);
						state <= ST_IDLE;
					end
				end

				ST_RMW_READ: begin
					if (i_rsp.ready) begin
						o_req.valid <= 1'b0;
						o_req.rw <= 1'b1;
						o_req.wdata <= store_merge(i_rsp.rdata, i_data.rd, addr.fields.offset,
							i_data.mem_width);
						state <= ST_RMW_WRITE;
					end
				end

				ST_RMW_WRITE: begin
					// Valid comes back one cycle after the read completed
					if (i_rsp.ready) begin
						o_req.valid <= 1'b0;
						o_req.rw <= 1'b0;
						o_data <= retired(i_data.rd);
						state <= ST_IDLE;
					end else begin
						o_req.valid <= 1'b1;
					end
				end

				ST_FLUSH: begin
					if (i_rsp.ready) begin
						o_req.valid <= 1'b0;
						o_req.flush <= 1'b0;
						o_data <= retired(i_data.rd);
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	localparam logic [3:0] CACHEABLE_REGION = 4'h2;
	localparam int DCACHE_INDEX_BITS = 4;
	localparam int DCACHE_LINES = 1 << DCACHE_INDEX_BITS;
	localparam int DCACHE_TAG_BITS = 32 - 4 - DCACHE_INDEX_BITS - 2;

	typedef struct packed {
		logic [3:0] region;
		logic [DCACHE_TAG_BITS-1:0] tag;
		logic [DCACHE_INDEX_BITS-1:0] index;
		logic [1:0] offset;
	} mem_addr_fields_t;

	// The same address seen as a flat word or split for the cache lookup
	typedef union packed {
		logic [31:0] word;
		mem_addr_fields_t fields;
	} mem_addr_u;

	typedef struct packed {
		logic valid;
		logic rw;
		logic flush;
		logic cacheable;
		mem_addr_u address;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
	} apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/stage_pkg.sv */
`default_nettype none

package stage_pkg;

	typedef logic [3:0] tag_t;

	typedef enum logic [1:0] {
		MEM_WIDTH_BYTE = 2'd0,
		MEM_WIDTH_HALF = 2'd1,
		MEM_WIDTH_WORD = 2'd2
	} mem_width_t;

	// Record handed over by the execute stage
	typedef struct packed {
		tag_t tag;
		logic mem_read;
		logic mem_write;
		logic mem_flush;
		mem_width_t mem_width;
		logic mem_signed;
		logic [31:0] mem_address;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} execute_data_t;

	typedef struct packed {
		tag_t tag;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} memory_data_t;

endpackage

`default_nettype wire
